//--- Bender.yml
package:
  name: rv_core

sources:
  - hdl/rv_isa_pkg.sv
  - hdl/core_pkg.sv
  - hdl/reg_file.sv
  - hdl/decode.sv
  - hdl/execute.sv
  - hdl/data_mem.sv
  - hdl/stage_ctrl.sv
  - hdl/core_top.sv
  - target: test
    files:
      - tb/core_properties.sv
      - tb/core_tb.sv

//--- hdl/core_pkg.sv
`default_nettype none

package core_pkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_addr_t;

   // Word address, byte address without the low two bits
   typedef logic [29:0] daddr_t;

   // One instruction in flight, one stage per cycle
   typedef enum logic [2:0] {
      FETCH,
      DECODE,
      EXECUTE,
      MEMORY,
      WRITEBACK
   } stage_t;

endpackage

`default_nettype wire

//--- hdl/core_top.sv
`timescale 1ns/100ps
`default_nettype none

module core_top
   import core_pkg::*, rv_isa_pkg::*;
#(
   parameter int DMEM_WORDS = 64
)
(
   input  wire       clk,
   input  wire       reset,
   input  word_t     instr_i,
   input  wire       instr_valid_i,
   output logic      instr_ready_o,
   output logic      wb_valid_o,
   output reg_addr_t wb_addr_o,
   output word_t     wb_data_o
);

   stage_t    stage;
   word_t     ir;
   word_t     operand_a, operand_b, store_data;
   alu_op_t   alu_op;
   iclass_t   dec_iclass, ex_iclass;
   reg_addr_t rd;
   word_t     alu_result, load_data, wb_data;
   logic      writes_reg;

   stage_ctrl u_stage_ctrl (
      .clk           (clk),
      .reset         (reset),
      .instr_i       (instr_i),
      .instr_valid_i (instr_valid_i),
      .instr_ready_o (instr_ready_o),
      .stage_o       (stage),
      .ir_o          (ir)
   );

   decode u_decode (
      .clk          (clk),
      .reset        (reset),
      .stage_i      (stage),
      .ir_i         (ir),
      .operand_a_o  (operand_a),
      .operand_b_o  (operand_b),
      .store_data_o (store_data),
      .alu_op_o     (alu_op),
      .iclass_o     (dec_iclass),
      .rd_o         (rd),
      .we_i         (wb_valid_o),
      .wd_i         (wb_data)
   );

   execute u_execute (
      .clk         (clk),
      .reset       (reset),
      .stage_i     (stage),
      .operand_a_i (operand_a),
      .operand_b_i (operand_b),
      .alu_op_i    (alu_op),
      .iclass_i    (dec_iclass),
      .result_o    (alu_result),
      .iclass_o    (ex_iclass)
   );

   data_mem #(
      .DMEM_WORDS (DMEM_WORDS)
   ) u_data_mem (
      .clk      (clk),
      .reset    (reset),
      .stage_i  (stage),
      .iclass_i (ex_iclass),
      .addr_i   (alu_result),
      .wdata_i  (store_data),
      .rdata_o  (load_data)
   );

   // Stores and unknown opcodes leave the register file alone
   assign writes_reg = (ex_iclass == RTYPE) || (ex_iclass == ITYPE) ||
                       (ex_iclass == LTYPE) || (ex_iclass == UTYPE);

   assign wb_data    = (ex_iclass == LTYPE) ? load_data : alu_result;
   assign wb_valid_o = (stage == WRITEBACK) && writes_reg && (rd != '0);
   assign wb_addr_o  = rd;
   assign wb_data_o  = wb_data;

endmodule

`default_nettype wire

//--- hdl/data_mem.sv
`timescale 1ns/100ps
`default_nettype none

module data_mem
   import core_pkg::*, rv_isa_pkg::*;
#(
   parameter int DMEM_WORDS = 64  // Power of two
)
(
   input  wire     clk,
   input  wire     reset,
   input  stage_t  stage_i,
   input  iclass_t iclass_i,
   input  word_t   addr_i,    // Byte address
   input  word_t   wdata_i,
   output word_t   rdata_o
);

   localparam int AW = $clog2(DMEM_WORDS);

   word_t           mem [DMEM_WORDS];
   daddr_t          word_addr;
   logic [AW-1:0]   idx;

   assign word_addr = addr_i[31:2];
   assign idx       = word_addr[AW-1:0]; // Wraps modulo DMEM_WORDS

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < DMEM_WORDS; i++) begin
            mem[i] <= '0;
         end
         rdata_o <= '0;
      end
      else if (stage_i == MEMORY) begin
         if (iclass_i == STYPE) begin
            mem[idx] <= wdata_i;
         end
         if (iclass_i == LTYPE) begin
            rdata_o <= mem[idx];
         end
      end
   end

endmodule

`default_nettype wire

//--- hdl/decode.sv
`timescale 1ns/100ps
`default_nettype none

module decode
   import core_pkg::*, rv_isa_pkg::*;
(
   input  wire       clk,
   input  wire       reset,
   input  stage_t    stage_i,
   input  word_t     ir_i,
   output word_t     operand_a_o,
   output word_t     operand_b_o,
   output word_t     store_data_o,
   output alu_op_t   alu_op_o,
   output iclass_t   iclass_o,
   output reg_addr_t rd_o,
   input  wire       we_i,   // Writeback strobe
   input  word_t     wd_i
);

   opcode_t    opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   word_t      imm_i, imm_s, imm_u;
   word_t      rs1_data, rs2_data;
   word_t      op_a_d, op_b_d, st_data_d;
   alu_op_t    alu_op_d;
   iclass_t    iclass_d;

   assign opcode = opcode_t'(ir_i[6:0]);
   assign funct3 = ir_i[14:12];
   assign funct7 = ir_i[31:25];

   assign imm_i = {{20{ir_i[31]}}, ir_i[31:20]};
   assign imm_s = {{20{ir_i[31]}}, ir_i[31:25], ir_i[11:7]};
   assign imm_u = {ir_i[31:12], 12'b0};

   // Write address comes back from rd_o, held since decode
   reg_file u_reg_file (
      .clk        (clk),
      .reset      (reset),
      .rs1_i      (ir_i[19:15]),
      .rs2_i      (ir_i[24:20]),
      .rs1_data_o (rs1_data),
      .rs2_data_o (rs2_data),
      .we_i       (we_i),
      .rd_i       (rd_o),
      .wd_i       (wd_i)
   );

   always_comb begin
      iclass_d  = NONE;
      alu_op_d  = ADD;
      op_a_d    = '0;
      op_b_d    = '0;
      st_data_d = '0;
      case (opcode)
         OP: begin
            op_a_d   = rs1_data;
            op_b_d   = rs2_data;
            iclass_d = RTYPE;
            case (funct3)
               F3_ADD_SUB: alu_op_d = (funct7 == F7_ALT) ? SUB : ADD;
               F3_SLL:     alu_op_d = SLL;
               F3_SLT:     alu_op_d = SLT;
               F3_XOR:     alu_op_d = XOR;
               F3_SRL:     alu_op_d = SRL;
               F3_OR:      alu_op_d = OR;
               F3_AND:     alu_op_d = AND;
               default:    iclass_d = NONE; // SLTU
            endcase
            // Alternate funct7 only valid for SUB here
            if (funct7 != F7_BASE && !(funct7 == F7_ALT && funct3 == F3_ADD_SUB)) begin
               iclass_d = NONE;
            end
         end
         OP_IMM: begin
            op_a_d   = rs1_data;
            op_b_d   = imm_i;
            iclass_d = ITYPE;
            case (funct3)
               F3_ADD_SUB: alu_op_d = ADD;
               F3_SLT:     alu_op_d = SLT;
               F3_XOR:     alu_op_d = XOR;
               F3_OR:      alu_op_d = OR;
               F3_AND:     alu_op_d = AND;
               default:    iclass_d = NONE; // Immediate shifts, SLTIU
            endcase
         end
         LOAD: begin
            op_a_d   = rs1_data;
            op_b_d   = imm_i;
            iclass_d = (funct3 == F3_WORD) ? LTYPE : NONE;
         end
         STORE: begin
            op_a_d    = rs1_data;
            op_b_d    = imm_s;
            st_data_d = rs2_data;
            iclass_d  = (funct3 == F3_WORD) ? STYPE : NONE;
         end
         LUI: begin
            op_b_d   = imm_u;
            alu_op_d = PASS_B;
            iclass_d = UTYPE;
         end
         default: iclass_d = NONE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         operand_a_o  <= '0;
         operand_b_o  <= '0;
         store_data_o <= '0;
         alu_op_o     <= ADD;
         iclass_o     <= NONE;
         rd_o         <= '0;
      end
      else if (stage_i == DECODE) begin
         operand_a_o  <= op_a_d;
         operand_b_o  <= op_b_d;
         store_data_o <= st_data_d;
         alu_op_o     <= alu_op_d;
         iclass_o     <= iclass_d;
         rd_o         <= ir_i[11:7];
      end
   end

endmodule

`default_nettype wire

//--- hdl/execute.sv
`timescale 1ns/100ps
`default_nettype none

module execute
   import core_pkg::*, rv_isa_pkg::*;
(
   input  wire     clk,
   input  wire     reset,
   input  stage_t  stage_i,
   input  word_t   operand_a_i,
   input  word_t   operand_b_i,
   input  alu_op_t alu_op_i,
   input  iclass_t iclass_i,
   output word_t   result_o,
   output iclass_t iclass_o
);

   word_t      alu_out;
   logic [4:0] shamt;
   logic       lt_signed;

   assign shamt     = operand_b_i[4:0];
   assign lt_signed = $signed(operand_a_i) < $signed(operand_b_i);

   // Loads and stores arrive as ADD, so this is also the address adder
   always_comb begin
      case (alu_op_i)
         ADD:     alu_out = operand_a_i + operand_b_i;
         SUB:     alu_out = operand_a_i - operand_b_i;
         AND:     alu_out = operand_a_i & operand_b_i;
         OR:      alu_out = operand_a_i | operand_b_i;
         XOR:     alu_out = operand_a_i ^ operand_b_i;
         SLL:     alu_out = operand_a_i << shamt;
         SRL:     alu_out = operand_a_i >> shamt;
         SLT:     alu_out = {31'b0, lt_signed};
         PASS_B:  alu_out = operand_b_i;
         default: alu_out = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         result_o <= '0;
         iclass_o <= NONE;
      end
      else if (stage_i == EXECUTE) begin
         result_o <= alu_out;
         iclass_o <= iclass_i;
      end
   end

endmodule

`default_nettype wire

//--- hdl/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file
   import core_pkg::*;
(
   input  wire       clk,
   input  wire       reset,
   input  reg_addr_t rs1_i,
   input  reg_addr_t rs2_i,
   output word_t     rs1_data_o,
   output word_t     rs2_data_o,
   input  wire       we_i,
   input  reg_addr_t rd_i,
   input  word_t     wd_i
);

   word_t regs [32];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end
      else if (we_i && rd_i != '0) begin
         regs[rd_i] <= wd_i;
      end
   end

   // x0 is hard-wired to zero
   assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
   assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

`default_nettype wire

//--- hdl/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

   // Major opcodes of the supported subset
   typedef enum logic [6:0] {
      LOAD   = 7'b0000011,
      OP_IMM = 7'b0010011,
      STORE  = 7'b0100011,
      OP     = 7'b0110011,
      LUI    = 7'b0110111
   } opcode_t;

   localparam logic [2:0] F3_ADD_SUB = 3'b000;
   localparam logic [2:0] F3_SLL     = 3'b001;
   localparam logic [2:0] F3_SLT     = 3'b010;
   localparam logic [2:0] F3_XOR     = 3'b100;
   localparam logic [2:0] F3_SRL     = 3'b101;
   localparam logic [2:0] F3_OR      = 3'b110;
   localparam logic [2:0] F3_AND     = 3'b111;
   localparam logic [2:0] F3_WORD    = 3'b010; // LW and SW width

   localparam logic [6:0] F7_BASE    = 7'b0000000;
   localparam logic [6:0] F7_ALT     = 7'b0100000; // SUB

   typedef enum logic [2:0] {
      RTYPE,
      ITYPE,
      LTYPE,
      STYPE,
      UTYPE,
      NONE
   } iclass_t;

   typedef enum logic [3:0] {
      ADD,
      SUB,
      AND,
      OR,
      XOR,
      SLL,
      SRL,
      SLT,
      PASS_B   // LUI
   } alu_op_t;

endpackage

`default_nettype wire

//--- hdl/stage_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module stage_ctrl
   import core_pkg::*;
(
   input  wire    clk,
   input  wire    reset,
   input  word_t  instr_i,
   input  wire    instr_valid_i,
   output logic   instr_ready_o,
   output stage_t stage_o,
   output word_t  ir_o
);

   stage_t stage_q, stage_d;
   logic   accept;

   assign instr_ready_o = (stage_q == FETCH);
   assign accept        = instr_ready_o && instr_valid_i;
   assign stage_o       = stage_q;

   always_comb begin
      case (stage_q)
         FETCH:     stage_d = accept ? DECODE : FETCH; // Wait for an instruction
         DECODE:    stage_d = EXECUTE;
         EXECUTE:   stage_d = MEMORY;
         MEMORY:    stage_d = WRITEBACK;
         WRITEBACK: stage_d = FETCH;
         default:   stage_d = FETCH;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         stage_q <= FETCH;
      end
      else begin
         stage_q <= stage_d;
      end
   end

   // Instruction register, only read from DECODE on
   always_ff @(posedge clk) begin
      if (accept) begin
         ir_o <= instr_i;
      end
   end

endmodule

`default_nettype wire

//--- rv_core.f
hdl/rv_isa_pkg.sv
hdl/core_pkg.sv
hdl/reg_file.sv
hdl/decode.sv
hdl/execute.sv
hdl/data_mem.sv
hdl/stage_ctrl.sv
hdl/core_top.sv
tb/core_properties.sv
tb/core_tb.sv

//--- tb/core_properties.sv
`timescale 1ns/100ps
`default_nettype none

module core_properties
   import core_pkg::*;
(
   input wire       clk,
   input wire       reset,
   input wire       instr_valid_i,
   input wire       instr_ready_i,
   input reg_addr_t instr_rd_i,   // rd field of the offered instruction
   input wire       wb_valid_i,
   input reg_addr_t wb_addr_i,
   input stage_t    stage_i
);

   int unsigned fail_count = 0;
   logic        accept;
   stage_t      next_stage;

   assign accept = instr_valid_i && instr_ready_i;

   always_comb begin
      if (stage_i == FETCH) begin
         next_stage = accept ? DECODE : FETCH;
      end
      else begin
         next_stage = (stage_i == WRITEBACK) ? FETCH : stage_t'(stage_i + 3'd1);
      end
   end

   wb_after_accept: assert property (@(posedge clk) disable iff (reset)
      wb_valid_i |-> $past(accept, 4) && stage_i == WRITEBACK)
   else begin
      fail_count++;
      $error("wb_valid_o high without an accept four cycles earlier");
   end

   // Busy from the accept edge until writeback is over
   ready_low: assert property (@(posedge clk) disable iff (reset)
      accept |=> !instr_ready_i [*4] ##1 instr_ready_i)
   else begin
      fail_count++;
      $error("instr_ready_o not low for the four busy cycles after an accept");
   end

   // Address must be the rd of the instruction taken at the accept edge
   wb_addr_nonzero: assert property (@(posedge clk) disable iff (reset)
      wb_valid_i |-> wb_addr_i != '0 && wb_addr_i == $past(instr_rd_i, 4))
   else begin
      fail_count++;
      $error("writeback to x0 or to a register other than the accepted rd");
   end

   stage_order: assert property (@(posedge clk) disable iff (reset)
      ##1 stage_i == $past(next_stage))
   else begin
      fail_count++;
      $error("stage out of order");
   end

endmodule

bind core_top core_properties u_core_properties (
   .clk           (clk),
   .reset         (reset),
   .instr_valid_i (instr_valid_i),
   .instr_ready_i (instr_ready_o),
   .instr_rd_i    (instr_i[11:7]),
   .wb_valid_i    (wb_valid_o),
   .wb_addr_i     (wb_addr_o),
   .stage_i       (stage)
);

`default_nettype wire

//--- tb/core_tb.sv
`timescale 1ns/100ps
`default_nettype none

module core_tb
   import core_pkg::*, rv_isa_pkg::*;
();

   localparam int WAIT_LIMIT = 50;

   logic      clk;
   logic      reset;
   word_t     instr_i;
   logic      instr_valid_i;
   logic      instr_ready_o;
   logic      wb_valid_o;
   reg_addr_t wb_addr_o;
   word_t     wb_data_o;

   word_t       shadow_regs [32] = '{default: '0};
   word_t       shadow_mem [64]  = '{default: '0};
   int          errors  = 0;
   int          checks  = 0;
   int          gap_max = 0;  // Longest idle gap before an instruction
   int unsigned seed    = 32'h6610_a977;

   core_top #(.DMEM_WORDS(64)) UUT (.*);

   always #5 clk = ~clk;

   task automatic finish_run();
      $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
               UUT.u_core_properties.fail_count);
      if (errors == 0 && UUT.u_core_properties.fail_count == 0) begin
         $display("Done: no errors");
      end
      else begin
         $display("Done: errors found");
      end
      $finish;
   endtask

   task automatic mismatch(input string name, input word_t exp, input word_t act);
      errors++;
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
   endtask

   task automatic wait_ready();
      for (int n = 0; n < WAIT_LIMIT && !instr_ready_o; n++) begin
         @(posedge clk);
         #1;
      end
      if (!instr_ready_o) begin
         errors++;
         $display("Timeout: the core never became ready for the next instruction");
         finish_run();
      end
   endtask

   // Issues one instruction and watches its writeback until the core is ready again
   task automatic run_instr(input word_t instr, input bit exp_wb, input reg_addr_t exp_addr,
                            input word_t exp_data, input string name);
      int cyc;
      bit seen;
      repeat ($urandom_range(0, gap_max)) begin
         @(posedge clk);
         #1;
      end
      wait_ready();
      instr_i       = instr;
      instr_valid_i = 1'b1;
      @(posedge clk);   // Accept edge
      #1;
      instr_valid_i = 1'b0;
      seen = 1'b0;
      cyc  = 1;
      for (int n = 0; n < WAIT_LIMIT && !instr_ready_o; n++) begin
         if (wb_valid_o) begin
            seen = 1'b1;
            if (exp_wb) begin
               checks++;
               assert (wb_addr_o == exp_addr) else mismatch({name, " addr"}, exp_addr, wb_addr_o);
               assert (wb_data_o == exp_data) else mismatch({name, " data"}, exp_data, wb_data_o);
               assert (cyc == 4) else mismatch({name, " latency"}, 32'd4, word_t'(cyc));
            end
         end
         @(posedge clk);
         #1;
         cyc++;
      end
      checks++;
      assert (seen == exp_wb) else begin
         errors++;
         $display("%s: writeback pulse %s", name, exp_wb ? "missing" : "not expected");
      end
      wait_ready();
   endtask

   function automatic word_t alu_model(input logic [2:0] f3, input bit sub, input word_t a,
                                       input word_t b);
      case (f3)
         F3_ADD_SUB: return sub ? a - b : a + b;
         F3_SLL:     return a << b[4:0];
         F3_SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         F3_XOR:     return a ^ b;
         F3_SRL:     return a >> b[4:0];
         F3_OR:      return a | b;
         default:    return a & b;
      endcase
   endfunction

   // R-type, or OP-IMM when use_imm is set
   task automatic do_alu(input logic [2:0] f3, input bit sub, input reg_addr_t rd,
                         input reg_addr_t rs1, input reg_addr_t rs2, input bit use_imm,
                         input logic [11:0] imm12, input string name);
      word_t b;
      word_t res;
      word_t instr;
      b   = use_imm ? {{20{imm12[11]}}, imm12} : shadow_regs[rs2];
      res = alu_model(f3, sub, shadow_regs[rs1], b);
      if (use_imm) begin
         instr = {imm12, rs1, f3, rd, OP_IMM};
      end
      else begin
         instr = {sub ? F7_ALT : F7_BASE, rs2, rs1, f3, rd, OP};
      end
      run_instr(instr, rd != 0, rd, res, name);
      if (rd != 0) begin
         shadow_regs[rd] = res;
      end
   endtask

   task automatic load_const(input reg_addr_t rd, input word_t c, input string name);
      logic [19:0] hi;
      hi = c[31:12] + c[11];   // ADDI adds the low part sign-extended
      run_instr({hi, rd, LUI}, rd != 0, rd, {hi, 12'b0}, {name, " lui"});
      if (rd != 0) begin
         shadow_regs[rd] = {hi, 12'b0};
      end
      do_alu(F3_ADD_SUB, 0, rd, rd, 0, 1, c[11:0], {name, " addi"});
   endtask

   task automatic do_mem(input bit store, input reg_addr_t rx, input reg_addr_t base,
                         input logic [11:0] imm12, input string name);
      word_t addr;
      int    idx;
      addr = shadow_regs[base] + {{20{imm12[11]}}, imm12};
      idx  = (addr >> 2) % 64;   // Word index wraps with the memory size
      if (store) begin
         run_instr({imm12[11:5], rx, base, F3_WORD, imm12[4:0], STORE}, 0, 0, 0, name);
         shadow_mem[idx] = shadow_regs[rx];
      end
      else begin
         run_instr({imm12, base, F3_WORD, rx, LOAD}, rx != 0, rx, shadow_mem[idx], name);
         if (rx != 0) begin
            shadow_regs[rx] = shadow_mem[idx];
         end
      end
   endtask

   task automatic random_op(input string name);
      logic [2:0] k;
      logic [2:0] f3;
      bit         use_imm;
      k       = 3'($urandom_range(0, 7));
      use_imm = 1'($urandom_range(0, 1));
      // SLTU slot becomes SUB, immediate shifts become ADDI
      f3 = (k == 3'd3 || (use_imm && (k == 3'd1 || k == 3'd5))) ? F3_ADD_SUB : k;
      do_alu(f3, !use_imm && k == 3'd3, 5'($urandom_range(1, 31)), 5'($urandom),
             5'($urandom), use_imm, 12'($urandom), name);
   endtask

   initial begin
      logic [11:0] offs [12];
      void'($urandom(seed));
      clk           = 1'b0;
      reset         = 1'b1;
      instr_i       = '0;
      instr_valid_i = 1'b0;
      repeat (8) @(posedge clk);
      #1;
      reset = 1'b0;

      for (int r = 1; r < 32; r++) begin
         do_alu(F3_ADD_SUB, 0, 5'(r), 0, 5'(r), 0, 12'd0, "reset_read");
      end

      // Odd registers get negative immediates
      for (int r = 1; r < 32; r++) begin
         do_alu(F3_ADD_SUB, 0, 5'(r), 0, 0, 1, {r[0], 11'($urandom)}, "addi_init");
      end
      repeat (60) random_op("alu_random");

      repeat (10) load_const(5'($urandom_range(1, 31)), $urandom, "const");

      // Base above 256 bytes, so every access aliases
      load_const(6, 32'h0000_0400 + ($urandom_range(0, 255) << 2), "mem_base");
      for (int i = 0; i < 12; i++) begin
         load_const(7, $urandom, "mem_data");
         offs[i] = 12'(($urandom_range(0, 63) << 2) - 128);
         do_mem(1, 7, 6, offs[i], "sw");
      end
      for (int i = 0; i < 12; i++) begin
         do_mem(0, 5'($urandom_range(8, 31)), 6, offs[i], "lw");
         do_mem(0, 5'($urandom_range(8, 31)), 6, offs[i] + 12'd256, "lw_alias");
      end

      do_alu(F3_ADD_SUB, 0, 0, 0, 0, 1, 12'h123, "x0_addi");
      do_alu(F3_OR, 0, 0, 5, 6, 0, 12'd0, "x0_or");
      run_instr({20'hABCDE, 5'd0, LUI}, 0, 0, 0, "x0_lui");
      do_alu(F3_OR, 0, 3, 0, 0, 0, 12'd0, "x0_read");
      run_instr(32'hFFFF_FFFF, 0, 0, 0, "unknown_op");   // Opcode 7'h7f
      do_alu(F3_ADD_SUB, 0, 4, 0, 0, 1, 12'd5, "after_unknown");

      gap_max = 6;
      repeat (30) random_op("gap_random");
      finish_run();
   end

endmodule

`default_nettype wire
